//--- src/exu_cfg.svh
// execute stage configuration macros, included by the package and by any module using them
`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// data path width, fixed by RV64
`define EXU_XLEN 64

// machine-mode CSR addresses
`define EXU_CSR_MSTATUS  12'h300
`define EXU_CSR_MTVEC    12'h305
`define EXU_CSR_MSCRATCH 12'h340
`define EXU_CSR_MEPC     12'h341
`define EXU_CSR_MCAUSE   12'h342

// mcause value for ecall from machine mode
`define EXU_CAUSE_ECALL_M 11

// one quotient bit per divider step
`define EXU_DIV_STEPS 64

`endif

//--- src/exu_pkg.sv
// shared types of the execute stage, referenced by scoped name from every module
`include "exu_cfg.svh"

package exu_pkg;

	typedef logic [`EXU_XLEN-1:0] xlen_t;
	typedef logic [31:0]          word_t;
	typedef logic [11:0]          csr_addr_t;
	typedef logic [`EXU_XLEN-1:0] pc_t;

	typedef enum logic [5:0] {
		op_add, op_sub, op_sll, op_slt, op_sltu,
		op_xor, op_srl, op_sra, op_or, op_and,
		op_addw, op_subw, op_sllw, op_srlw, op_sraw,
		// M extension
		op_mul, op_mulh, op_mulhsu, op_mulhu, op_mulw,
		op_div, op_divu, op_rem, op_remu,
		op_divw, op_divuw, op_remw, op_remuw,
		// load/store address and jumps
		op_lsaddr, op_link,
		// system
		op_csrrw, op_csrrs, op_csrrc, op_ecall, op_mret
	} exu_op_e;

	// decoded operation; imm doubles as the CSR address
	typedef struct packed {
		exu_op_e   op;
		xlen_t     op1;
		xlen_t     op2;
		csr_addr_t imm;
		pc_t       pc;
	} exu_req_t;

	typedef struct packed {
		xlen_t data;
		xlen_t store_data;
		logic  redirect;
		pc_t   redirect_pc;
	} exu_res_t;

	typedef struct packed {
		xlen_t dividend;
		xlen_t divisor;
		logic  is_signed;
		logic  is_word;
		logic  want_rem;
	} div_req_t;

	typedef enum logic [1:0] {
		ds_idle,
		ds_run,
		ds_done
	} div_state_e;

endpackage

//--- src/exu_alu.sv
// single-cycle integer, shift, compare, multiply and address unit of the execute stage
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_alu (
	input  exu_pkg::exu_req_t req,
	output exu_pkg::xlen_t    data
);

	exu_pkg::word_t addw_w;
	exu_pkg::word_t subw_w;
	exu_pkg::word_t sllw_w;
	exu_pkg::word_t srlw_w;
	exu_pkg::word_t sraw_w;
	logic lt_s;
	logic lt_u;
	logic a_sgn;
	logic b_sgn;
	logic [2*`EXU_XLEN-1:0] a_wide;
	logic [2*`EXU_XLEN-1:0] b_wide;
	logic [2*`EXU_XLEN-1:0] prod;

	// word forms work on the low half only
	assign addw_w = req.op1[31:0] + req.op2[31:0];
	assign subw_w = req.op1[31:0] - req.op2[31:0];
	assign sllw_w = req.op1[31:0] << req.op2[4:0];
	assign srlw_w = req.op1[31:0] >> req.op2[4:0];
	assign sraw_w = exu_pkg::word_t'($signed(req.op1[31:0]) >>> req.op2[4:0]);

	assign lt_s = $signed(req.op1) < $signed(req.op2);
	assign lt_u = req.op1 < req.op2;

	// one shared product, operands extended per mulh variant
	assign a_sgn = (req.op == exu_pkg::op_mulh) || (req.op == exu_pkg::op_mulhsu);
	assign b_sgn = (req.op == exu_pkg::op_mulh);
	assign a_wide = {{`EXU_XLEN{a_sgn & req.op1[`EXU_XLEN-1]}}, req.op1};
	assign b_wide = {{`EXU_XLEN{b_sgn & req.op2[`EXU_XLEN-1]}}, req.op2};
	assign prod = a_wide * b_wide;

	always_comb begin
		case (req.op)
			exu_pkg::op_add:    data = req.op1 + req.op2;
			exu_pkg::op_sub:    data = req.op1 - req.op2;
			exu_pkg::op_sll:    data = req.op1 << req.op2[5:0];
			exu_pkg::op_slt:    data = exu_pkg::xlen_t'(lt_s);
			exu_pkg::op_sltu:   data = exu_pkg::xlen_t'(lt_u);
			exu_pkg::op_xor:    data = req.op1 ^ req.op2;
			exu_pkg::op_srl:    data = req.op1 >> req.op2[5:0];
			exu_pkg::op_sra:    data = $signed(req.op1) >>> req.op2[5:0];
			exu_pkg::op_or:     data = req.op1 | req.op2;
			exu_pkg::op_and:    data = req.op1 & req.op2;
			exu_pkg::op_addw:   data = {{32{addw_w[31]}}, addw_w};
			exu_pkg::op_subw:   data = {{32{subw_w[31]}}, subw_w};
			exu_pkg::op_sllw:   data = {{32{sllw_w[31]}}, sllw_w};
			exu_pkg::op_srlw:   data = {{32{srlw_w[31]}}, srlw_w};
			exu_pkg::op_sraw:   data = {{32{sraw_w[31]}}, sraw_w};
			exu_pkg::op_mul:    data = prod[`EXU_XLEN-1:0];
			exu_pkg::op_mulh,
			exu_pkg::op_mulhsu,
			exu_pkg::op_mulhu:  data = prod[2*`EXU_XLEN-1:`EXU_XLEN];
			exu_pkg::op_mulw:   data = {{32{prod[31]}}, prod[31:0]};
			// imm is sign-extended as a 12-bit offset
			exu_pkg::op_lsaddr: data = req.op1 + {{(`EXU_XLEN-12){req.imm[11]}}, req.imm};
			exu_pkg::op_link:   data = req.pc + 'd4;
			default:            data = '0;
		endcase
	end

endmodule

//--- src/exu_div.sv
// iterative radix-2 restoring divider for div, divu, rem, remu and their word forms
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_div (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              start,
	input  exu_pkg::div_req_t req,
	output logic              busy,
	output logic              done,
	output exu_pkg::xlen_t    data
);

	localparam int unsigned cnt_w = $clog2(`EXU_DIV_STEPS);

	exu_pkg::div_state_e state;
	logic [cnt_w-1:0] step_cnt;
	exu_pkg::xlen_t quo_q, rem_q, divisor_q, dividend_q;
	logic q_neg_q, r_neg_q, zero_q, ovf_q, word_q, want_rem_q;
	exu_pkg::word_t a_lo, b_lo;
	exu_pkg::xlen_t a_ext, b_ext, a_mag, b_mag, ovf_min;
	exu_pkg::xlen_t q_fix, r_fix, res;
	logic a_neg, b_neg;
	logic [`EXU_XLEN:0] shifted, diff;

	// operand conditioning, narrowed first for word forms
	always_comb begin
		a_lo = req.dividend[31:0];
		b_lo = req.divisor[31:0];
		a_ext = req.dividend;
		b_ext = req.divisor;
		ovf_min = {1'b1, {(`EXU_XLEN-1){1'b0}}};
		if (req.is_word) begin
			a_ext = {{32{req.is_signed & a_lo[31]}}, a_lo};
			b_ext = {{32{req.is_signed & b_lo[31]}}, b_lo};
			ovf_min = {{33{1'b1}}, 31'd0};
		end
		a_neg = req.is_signed & a_ext[`EXU_XLEN-1];
		b_neg = req.is_signed & b_ext[`EXU_XLEN-1];
		a_mag = a_neg ? -a_ext : a_ext;
		b_mag = b_neg ? -b_ext : b_ext;
	end

	assign shifted = {rem_q, quo_q[`EXU_XLEN-1]};
	assign diff = shifted - {1'b0, divisor_q};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= exu_pkg::ds_idle;
			step_cnt <= '0;
		end else begin
			case (state)
				exu_pkg::ds_idle: if (start) begin
					state <= exu_pkg::ds_run;
					step_cnt <= '0;
				end
				exu_pkg::ds_run: begin
					step_cnt <= step_cnt + 1'b1;
					if (step_cnt == cnt_w'(`EXU_DIV_STEPS - 1))
						state <= exu_pkg::ds_done;
				end
				default: state <= exu_pkg::ds_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == exu_pkg::ds_idle && start) begin
			quo_q <= a_mag;
			rem_q <= '0;
			divisor_q <= b_mag;
			dividend_q <= a_ext;
			q_neg_q <= a_neg ^ b_neg;
			r_neg_q <= a_neg;
			zero_q <= (b_ext == '0);
			ovf_q <= req.is_signed && (a_ext == ovf_min) && (b_ext == '1);
			word_q <= req.is_word;
			want_rem_q <= req.want_rem;
		end else if (state == exu_pkg::ds_run) begin
			// borrow set means the trial subtract failed
			if (!diff[`EXU_XLEN]) begin
				rem_q <= diff[`EXU_XLEN-1:0];
				quo_q <= {quo_q[`EXU_XLEN-2:0], 1'b1};
			end else begin
				rem_q <= shifted[`EXU_XLEN-1:0];
				quo_q <= {quo_q[`EXU_XLEN-2:0], 1'b0};
			end
		end
	end

	// sign fix-up and RISC-V special cases
	always_comb begin
		q_fix = q_neg_q ? -quo_q : quo_q;
		r_fix = r_neg_q ? -rem_q : rem_q;
		if (zero_q) begin
			q_fix = '1;
			r_fix = dividend_q;
		end else if (ovf_q) begin
			q_fix = dividend_q;
			r_fix = '0;
		end
		res = want_rem_q ? r_fix : q_fix;
		data = word_q ? {{32{res[31]}}, res[31:0]} : res;
	end

	assign busy = (state != exu_pkg::ds_idle);
	assign done = (state == exu_pkg::ds_done);

endmodule

//--- src/exu_csr.sv
// machine-mode CSR file with csrrw/csrrs/csrrc access plus ecall and mret trap targets
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_csr (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              en,
	input  exu_pkg::exu_req_t req,
	output exu_pkg::xlen_t    rdata,
	output exu_pkg::pc_t      target
);

	exu_pkg::xlen_t mstatus, mtvec, mepc, mcause, mscratch;
	exu_pkg::xlen_t wdata;
	logic is_rw;

	always_comb begin
		case (req.imm)
			`EXU_CSR_MSTATUS:  rdata = mstatus;
			`EXU_CSR_MTVEC:    rdata = mtvec;
			`EXU_CSR_MEPC:     rdata = mepc;
			`EXU_CSR_MCAUSE:   rdata = mcause;
			`EXU_CSR_MSCRATCH: rdata = mscratch;
			default:           rdata = '0;
		endcase
	end

	// new value from the old one and op1
	always_comb begin
		case (req.op)
			exu_pkg::op_csrrs: wdata = rdata | req.op1;
			exu_pkg::op_csrrc: wdata = rdata & ~req.op1;
			default:           wdata = req.op1;
		endcase
	end

	assign is_rw = (req.op == exu_pkg::op_csrrw) || (req.op == exu_pkg::op_csrrs) ||
		(req.op == exu_pkg::op_csrrc);

	// trap vector on ecall, return address otherwise
	assign target = (req.op == exu_pkg::op_ecall) ? mtvec : mepc;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mstatus <= '0;
			mtvec <= '0;
			mepc <= '0;
			mcause <= '0;
			mscratch <= '0;
		end else if (en) begin
			if (req.op == exu_pkg::op_ecall) begin
				mepc <= req.pc;
				mcause <= exu_pkg::xlen_t'(`EXU_CAUSE_ECALL_M);
			end else if (is_rw) begin
				case (req.imm)
					`EXU_CSR_MSTATUS:  mstatus <= wdata;
					`EXU_CSR_MTVEC:    mtvec <= wdata;
					`EXU_CSR_MEPC:     mepc <= wdata;
					`EXU_CSR_MCAUSE:   mcause <= wdata;
					`EXU_CSR_MSCRATCH: mscratch <= wdata;
					default:           ;
				endcase
			end
		end
	end

endmodule

//--- src/exu_stage.sv
// execute control: accepts one request, dispatches it to ALU, divider or CSR file, holds result
`timescale 1ns/1ps

module exu_stage (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              in_valid,
	input  exu_pkg::exu_req_t in_req,
	output logic              in_ready,
	output logic              out_valid,
	output exu_pkg::exu_res_t out_res,
	input  logic              out_ready,
	output exu_pkg::exu_req_t alu_req,
	input  exu_pkg::xlen_t    alu_data,
	output logic              div_start,
	output exu_pkg::div_req_t div_req,
	input  logic              div_busy,
	input  logic              div_done,
	input  exu_pkg::xlen_t    div_data,
	output logic              csr_en,
	output exu_pkg::exu_req_t csr_req,
	input  exu_pkg::xlen_t    csr_rdata,
	input  exu_pkg::pc_t      csr_target
);

	typedef enum logic [1:0] {
		st_idle,
		st_exec,
		st_div_wait,
		st_hold
	} stage_state_e;

	stage_state_e state;
	exu_pkg::exu_req_t req_q;
	exu_pkg::exu_res_t res_d;
	logic is_div, is_csr_rw, is_csr;

	// opcode classes
	always_comb begin
		is_div = 1'b0;
		is_csr_rw = 1'b0;
		is_csr = 1'b0;
		div_req.dividend = req_q.op1;
		div_req.divisor = req_q.op2;
		div_req.is_signed = 1'b0;
		div_req.is_word = 1'b0;
		div_req.want_rem = 1'b0;
		case (req_q.op)
			exu_pkg::op_div:   {is_div, div_req.is_signed} = 2'b11;
			exu_pkg::op_divu:  is_div = 1'b1;
			exu_pkg::op_rem:   {is_div, div_req.is_signed, div_req.want_rem} = 3'b111;
			exu_pkg::op_remu:  {is_div, div_req.want_rem} = 2'b11;
			exu_pkg::op_divw:  {is_div, div_req.is_signed, div_req.is_word} = 3'b111;
			exu_pkg::op_divuw: {is_div, div_req.is_word} = 2'b11;
			exu_pkg::op_remw:  {is_div, div_req.is_signed, div_req.is_word, div_req.want_rem} = '1;
			exu_pkg::op_remuw: {is_div, div_req.is_word, div_req.want_rem} = 3'b111;
			exu_pkg::op_csrrw,
			exu_pkg::op_csrrs,
			exu_pkg::op_csrrc: {is_csr, is_csr_rw} = 2'b11;
			exu_pkg::op_ecall,
			exu_pkg::op_mret:  is_csr = 1'b1;
			default:           ;
		endcase
	end

	// result assembly
	always_comb begin
		if (state == st_div_wait)
			res_d.data = div_data;
		else
			res_d.data = is_csr_rw ? csr_rdata : alu_data;
		res_d.store_data = req_q.op2;
		res_d.redirect = 1'b0;
		res_d.redirect_pc = '0;
		case (req_q.op)
			exu_pkg::op_ecall,
			exu_pkg::op_mret: begin
				res_d.redirect = 1'b1;
				res_d.redirect_pc = csr_target;
			end
			// target offset arrives in op2
			exu_pkg::op_link: begin
				res_d.redirect = 1'b1;
				res_d.redirect_pc = req_q.pc + req_q.op2;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready)
			req_q <= in_req;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			out_res <= '0;
		end else begin
			case (state)
				st_idle: if (in_valid) state <= st_exec;
				st_exec: begin
					if (!is_div) begin
						out_res <= res_d;
						state <= st_hold;
					end else if (!div_busy) begin
						state <= st_div_wait;
					end
				end
				st_div_wait: if (div_done) begin
					out_res <= res_d;
					state <= st_hold;
				end
				default: if (out_ready) state <= st_idle;
			endcase
		end
	end

	assign in_ready = (state == st_idle);
	assign out_valid = (state == st_hold);
	assign div_start = (state == st_exec) && is_div && !div_busy;
	assign csr_en = (state == st_exec) && is_csr;
	assign alu_req = req_q;
	assign csr_req = req_q;

endmodule

//--- src/exu_top.sv
// execute stage top level, joining the control to the ALU, divider and CSR file
`timescale 1ns/1ps

module exu_top (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              in_valid,
	input  exu_pkg::exu_req_t in_req,
	output logic              in_ready,
	output logic              out_valid,
	output exu_pkg::exu_res_t out_res,
	input  logic              out_ready
);

	exu_pkg::exu_req_t alu_req, csr_req;
	exu_pkg::xlen_t    alu_data, div_data, csr_rdata;
	exu_pkg::div_req_t div_req;
	exu_pkg::pc_t      csr_target;
	logic              div_start, div_busy, div_done, csr_en;

	exu_stage stage_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.in_valid   (in_valid),
		.in_req     (in_req),
		.in_ready   (in_ready),
		.out_valid  (out_valid),
		.out_res    (out_res),
		.out_ready  (out_ready),
		.alu_req    (alu_req),
		.alu_data   (alu_data),
		.div_start  (div_start),
		.div_req    (div_req),
		.div_busy   (div_busy),
		.div_done   (div_done),
		.div_data   (div_data),
		.csr_en     (csr_en),
		.csr_req    (csr_req),
		.csr_rdata  (csr_rdata),
		.csr_target (csr_target)
	);

	exu_alu alu_i (
		.req  (alu_req),
		.data (alu_data)
	);

	exu_div div_i (
		.clk    (clk),
		.arst_n (arst_n),
		.start  (div_start),
		.req    (div_req),
		.busy   (div_busy),
		.done   (div_done),
		.data   (div_data)
	);

	exu_csr csr_i (
		.clk    (clk),
		.arst_n (arst_n),
		.en     (csr_en),
		.req    (csr_req),
		.rdata  (csr_rdata),
		.target (csr_target)
	);

endmodule

//--- verif/exu_tb.sv
// table-driven testbench for the execute stage top level, run through tb.f
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_tb;

	typedef struct packed {
		exu_pkg::exu_req_t req;
		exu_pkg::exu_res_t exp;
		logic              data_known;
	} entry_t;

	logic              clk;
	logic              arst_n;
	logic              in_valid;
	exu_pkg::exu_req_t in_req;
	logic              in_ready;
	logic              out_valid;
	exu_pkg::exu_res_t out_res;
	logic              out_ready;

	entry_t entries[$];
	integer seed = 32'hd122_513b;
	int     val_errs;
	int     proto_errs;
	int     rx_cnt;

	exu_top exu_top_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_req    (in_req),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_res   (out_res),
		.out_ready (out_ready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic push_entry(input exu_pkg::exu_op_e op, input exu_pkg::xlen_t op1,
		input exu_pkg::xlen_t op2, input exu_pkg::csr_addr_t imm, input exu_pkg::pc_t pc,
		input exu_pkg::xlen_t data, input logic known, input logic redir,
		input exu_pkg::pc_t redir_pc);
		entry_t e;
		e = '0;
		e.req.op = op;
		e.req.op1 = op1;
		e.req.op2 = op2;
		e.req.imm = imm;
		e.req.pc = pc;
		e.exp.data = data;
		// store data is op2 passed through
		e.exp.store_data = op2;
		e.exp.redirect = redir;
		e.exp.redirect_pc = redir_pc;
		e.data_known = known;
		entries.push_back(e);
	endtask

	task automatic push_alu(input exu_pkg::exu_op_e op, input exu_pkg::xlen_t op1,
		input exu_pkg::xlen_t op2, input exu_pkg::xlen_t data);
		push_entry(op, op1, op2, 12'h0, 64'h0, data, 1'b1, 1'b0, 64'h0);
	endtask

	task automatic push_csr(input exu_pkg::exu_op_e op, input exu_pkg::csr_addr_t addr,
		input exu_pkg::xlen_t op1, input exu_pkg::xlen_t data);
		push_entry(op, op1, 64'h0, addr, 64'h0, data, 1'b1, 1'b0, 64'h0);
	endtask

	task automatic load_table();
		push_alu(exu_pkg::op_add, 64'h5, 64'hffff_ffff_ffff_fffd, 64'h2);
		push_alu(exu_pkg::op_sub, 64'h3, 64'h5, 64'hffff_ffff_ffff_fffe);
		// only the low 6 bits shift
		push_alu(exu_pkg::op_sll, 64'h1, 64'h43, 64'h8);
		push_alu(exu_pkg::op_slt, 64'hffff_ffff_ffff_ffff, 64'h1, 64'h1);
		push_alu(exu_pkg::op_sltu, 64'hffff_ffff_ffff_ffff, 64'h1, 64'h0);
		push_alu(exu_pkg::op_xor, 64'hf0f0_f0f0_f0f0_f0f0, 64'hff00_ff00_ff00_ff00,
			64'h0ff0_0ff0_0ff0_0ff0);
		push_alu(exu_pkg::op_srl, 64'h8000_0000_0000_0000, 64'h4, 64'h0800_0000_0000_0000);
		push_alu(exu_pkg::op_sra, 64'h8000_0000_0000_0000, 64'h4, 64'hf800_0000_0000_0000);
		push_alu(exu_pkg::op_or, 64'h0000_00ff_0000_0000, 64'hff, 64'h0000_00ff_0000_00ff);
		push_alu(exu_pkg::op_and, 64'hf0f0_f0f0_f0f0_f0f0, 64'hff00_ff00_ff00_ff00,
			64'hf000_f000_f000_f000);
		push_alu(exu_pkg::op_addw, 64'h7fff_ffff, 64'h1, 64'hffff_ffff_8000_0000);
		push_alu(exu_pkg::op_subw, 64'h1234_5678_0000_0000, 64'h1, 64'hffff_ffff_ffff_ffff);
		push_alu(exu_pkg::op_sllw, 64'h1, 64'h3f, 64'hffff_ffff_8000_0000);
		push_alu(exu_pkg::op_srlw, 64'hffff_ffff_8000_0000, 64'h4, 64'h0800_0000);
		push_alu(exu_pkg::op_sraw, 64'h8000_0000, 64'h4, 64'hffff_ffff_f800_0000);
		push_entry(exu_pkg::op_lsaddr, 64'h1000, 64'hdead_beef_cafe_f00d, 12'hff8, 64'h0,
			64'hff8, 1'b1, 1'b0, 64'h0);
		// multiplier halves, mixed signs
		push_alu(exu_pkg::op_mul, 64'hffff_ffff_ffff_fffe, 64'h3, 64'hffff_ffff_ffff_fffa);
		push_alu(exu_pkg::op_mulh, 64'hffff_ffff_ffff_fffd, 64'h8000_0000_0000_0000, 64'h1);
		push_alu(exu_pkg::op_mulhsu, 64'hffff_ffff_ffff_fffd, 64'h8000_0000_0000_0000,
			64'hffff_ffff_ffff_fffe);
		push_alu(exu_pkg::op_mulhu, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff,
			64'hffff_ffff_ffff_fffe);
		push_alu(exu_pkg::op_mulw, 64'habcd_0000_0001_0000, 64'h8000, 64'hffff_ffff_8000_0000);
		// divider
		push_alu(exu_pkg::op_div, 64'hffff_ffff_ffff_fff9, 64'h2, 64'hffff_ffff_ffff_fffd);
		push_alu(exu_pkg::op_rem, 64'hffff_ffff_ffff_fff9, 64'h2, 64'hffff_ffff_ffff_ffff);
		push_alu(exu_pkg::op_divu, 64'h64, 64'h7, 64'he);
		push_alu(exu_pkg::op_remu, 64'h64, 64'h7, 64'h2);
		push_alu(exu_pkg::op_remu, 64'hffff_ffff_ffff_ffff, 64'h8000_0000_0000_0000,
			64'h7fff_ffff_ffff_ffff);
		push_alu(exu_pkg::op_div, 64'h5, 64'h0, 64'hffff_ffff_ffff_ffff);
		push_alu(exu_pkg::op_rem, 64'h5, 64'h0, 64'h5);
		push_alu(exu_pkg::op_divu, 64'h1234, 64'h0, 64'hffff_ffff_ffff_ffff);
		push_alu(exu_pkg::op_remu, 64'h1234, 64'h0, 64'h1234);
		push_alu(exu_pkg::op_div, 64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff,
			64'h8000_0000_0000_0000);
		push_alu(exu_pkg::op_rem, 64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff, 64'h0);
		push_alu(exu_pkg::op_divw, 64'h1234_5678_ffff_fff9, 64'h2, 64'hffff_ffff_ffff_fffd);
		push_alu(exu_pkg::op_divuw, 64'hffff_ffff_ffff_fff9, 64'h2, 64'h7fff_fffc);
		push_alu(exu_pkg::op_remw, 64'hffff_ffff_ffff_fff9, 64'haaaa_0000_0000_0003,
			64'hffff_ffff_ffff_ffff);
		push_alu(exu_pkg::op_remuw, 64'hffff_ffff_ffff_fff9, 64'h10, 64'h9);
		push_alu(exu_pkg::op_divw, 64'h8000_0000, 64'hffff_ffff, 64'hffff_ffff_8000_0000);
		push_alu(exu_pkg::op_remw, 64'h8000_0005, 64'hffff_ffff_0000_0000,
			64'hffff_ffff_8000_0005);
		push_alu(exu_pkg::op_divuw, 64'h5, 64'h1_0000_0000, 64'hffff_ffff_ffff_ffff);
		// CSR accesses return the old value
		push_csr(exu_pkg::op_csrrw, `EXU_CSR_MTVEC, 64'h8000_0100, 64'h0);
		push_csr(exu_pkg::op_csrrs, `EXU_CSR_MSCRATCH, 64'h0f, 64'h0);
		push_csr(exu_pkg::op_csrrs, `EXU_CSR_MSCRATCH, 64'hf0, 64'h0f);
		push_csr(exu_pkg::op_csrrc, `EXU_CSR_MSCRATCH, 64'h3c, 64'hff);
		push_csr(exu_pkg::op_csrrs, `EXU_CSR_MSCRATCH, 64'h0, 64'hc3);
		push_csr(exu_pkg::op_csrrs, `EXU_CSR_MTVEC, 64'h0, 64'h8000_0100);
		push_csr(exu_pkg::op_csrrw, 12'h7c0, 64'h55, 64'h0);
		// trap entry and return
		push_entry(exu_pkg::op_ecall, 64'h0, 64'h0, 12'h0, 64'h8000_2000, 64'h0, 1'b0, 1'b1,
			64'h8000_0100);
		push_csr(exu_pkg::op_csrrs, `EXU_CSR_MEPC, 64'h0, 64'h8000_2000);
		push_csr(exu_pkg::op_csrrs, `EXU_CSR_MCAUSE, 64'h0, 64'd11);
		push_entry(exu_pkg::op_mret, 64'h0, 64'h0, 12'h0, 64'h8000_2400, 64'h0, 1'b0, 1'b1,
			64'h8000_2000);
		push_entry(exu_pkg::op_link, 64'h0, 64'hffff_ffff_ffff_ff00, 12'h0, 64'h8000_3000,
			64'h8000_3004, 1'b1, 1'b1, 64'h8000_2f00);
	endtask

	task automatic check_data(input string name, input int idx, input exu_pkg::xlen_t got,
		input exu_pkg::xlen_t exp);
		if (got !== exp) begin
			$display("FAIL %s entry %0d: got %h expected %h", name, idx, got, exp);
			val_errs++;
		end
	endtask

	task automatic check_redirect(input int idx, input logic got_flag, input exu_pkg::pc_t got_pc,
		input logic exp_flag, input exu_pkg::pc_t exp_pc);
		if (got_flag !== exp_flag) begin
			$display("FAIL out_res.redirect entry %0d: got %h expected %h", idx, got_flag,
				exp_flag);
			val_errs++;
		end else if (exp_flag && got_pc !== exp_pc) begin
			$display("FAIL out_res.redirect_pc entry %0d: got %h expected %h", idx, got_pc,
				exp_pc);
			val_errs++;
		end
	endtask

	task automatic drive_table();
		for (int i = 0; i < entries.size(); i++) begin
			in_valid = 1'b1;
			in_req = entries[i].req;
			while (in_ready !== 1'b1) begin
				@(posedge clk);
				#1;
			end
			@(posedge clk);
			#1;
		end
		in_valid = 1'b0;
	endtask

	// output side with random back-pressure
	initial begin : collect
		integer rnd;
		exu_pkg::exu_res_t held;
		logic stalled;
		stalled = 1'b0;
		held = '0;
		@(posedge arst_n);
		forever begin
			@(posedge clk);
			#1;
			rnd = $random(seed);
			out_ready = rnd[0];
			if (stalled && (out_valid !== 1'b1 || out_res !== held)) begin
				$display("result was dropped or changed while out_ready was low");
				proto_errs++;
			end
			if (out_valid === 1'b1 && out_ready) begin
				if (rx_cnt >= entries.size()) begin
					$display("an extra result arrived after the whole table was done");
					proto_errs++;
				end else begin
					if (entries[rx_cnt].data_known)
						check_data("out_res.data", rx_cnt, out_res.data,
							entries[rx_cnt].exp.data);
					check_data("out_res.store_data", rx_cnt, out_res.store_data,
						entries[rx_cnt].exp.store_data);
					check_redirect(rx_cnt, out_res.redirect, out_res.redirect_pc,
						entries[rx_cnt].exp.redirect, entries[rx_cnt].exp.redirect_pc);
				end
				rx_cnt++;
			end
			stalled = (out_valid === 1'b1) && !out_ready;
			held = out_res;
		end
	end

	initial begin : watchdog
		int unsigned cycles;
		int unsigned limit;
		cycles = 0;
		@(posedge arst_n);
		limit = entries.size() * (`EXU_DIV_STEPS + 10);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles with %0d of %0d results received", cycles, rx_cnt,
			entries.size());
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		arst_n = 1'b0;
		in_valid = 1'b0;
		in_req = '0;
		out_ready = 1'b0;
		val_errs = 0;
		proto_errs = 0;
		rx_cnt = 0;
		load_table();
		repeat (4) @(posedge clk);
		#1;
		arst_n = 1'b1;
		if (in_ready !== 1'b1 || out_valid !== 1'b0 || out_res.redirect !== 1'b0) begin
			$display("after reset in_ready is not high or out_valid and redirect are not low");
			proto_errs++;
		end
		drive_table();
		wait (rx_cnt >= entries.size());
		// catch duplicated results
		repeat (10) @(posedge clk);
		#1;
		$display("results %0d of %0d, value errors %0d, protocol errors %0d", rx_cnt,
			entries.size(), val_errs, proto_errs);
		if (val_errs == 0 && proto_errs == 0 && rx_cnt == entries.size())
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- tb.f
+incdir+src
src/exu_pkg.sv
src/exu_alu.sv
src/exu_div.sv
src/exu_csr.sv
src/exu_stage.sv
src/exu_top.sv
verif/exu_tb.sv

//--- Makefile
# Verilator build and run of the execute stage testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -f tb.f --top-module exu_tb

run: compile
	./obj_dir/Vexu_tb | tee run.log
	grep -qF "*** TEST PASSED ***" run.log

clean:
	rm -rf obj_dir run.log
